//--- issue_pkg.sv
package issue_pkg;

    // fetch starts here after reset
    parameter logic [31:0] reset_pc = 32'h0000_3000;

    // physical registers 0..31 carry the reset mapping
    parameter int num_logical = 32;

    // funct codes of the two supported R-type operations
    parameter logic [5:0] funct_addu = 6'h21;
    parameter logic [5:0] funct_subu = 6'h23;

    typedef enum logic [3:0] {
        alu_r,
        ori,
        lui,
        lw,
        sw,
        beq,
        j,
        jal,
        other
    } op_class_t;

    // has_dst is only set for a write to a register other than $0
    typedef struct packed {
        op_class_t   op_class;
        logic [4:0]  rs;
        logic        rs_valid;
        logic [4:0]  rt;
        logic        rt_valid;
        logic [4:0]  dst_lr;
        logic        has_dst;
        logic [31:0] imm;
        logic [25:0] jump_target;
    } decoded_t;

endpackage

//--- rename_if.sv
`timescale 1ns/1ps

interface rename_if #(
    parameter int num_phy_regs = 64
);

    localparam int pr_w = $clog2(num_phy_regs);

    // mappings for the instruction at the current PC
    logic [pr_w-1:0] phy_rs;
    logic [pr_w-1:0] phy_rt;
    logic [pr_w-1:0] phy_dst;
    logic            ready;

    // issue commits the allocation on the next edge
    logic            take;

    modport rename (output phy_rs, phy_rt, phy_dst, ready, input take);

    modport stage (input phy_rs, phy_rt, phy_dst, ready, output take);

endinterface

//--- opcode_decoder.sv
`timescale 1ns/1ps

module opcode_decoder (
    input  logic [31:0]       instr,
    output issue_pkg::decoded_t dec
);

    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rd;
    logic       writes;
    logic [4:0] dst;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rd     = instr[15:11];

    always_comb begin
        dec.op_class    = issue_pkg::other;
        dec.rs          = instr[25:21];
        dec.rt          = instr[20:16];
        dec.rs_valid    = 1'b0;
        dec.rt_valid    = 1'b0;
        dec.imm         = {{16{instr[15]}}, instr[15:0]};
        dec.jump_target = instr[25:0];
        writes          = 1'b0;
        dst             = 5'd0;

        case (opcode)
            op_special: begin
                if (funct == issue_pkg::funct_addu || funct == issue_pkg::funct_subu) begin
                    dec.op_class = issue_pkg::alu_r;
                    dec.rs_valid = 1'b1;
                    dec.rt_valid = 1'b1;
                    writes       = 1'b1;
                    dst          = rd;
                end
            end
            op_ori: begin
                dec.op_class = issue_pkg::ori;
                dec.rs_valid = 1'b1;
                writes       = 1'b1;
                dst          = instr[20:16];
            end
            op_lui: begin
                dec.op_class = issue_pkg::lui;
                writes       = 1'b1;
                dst          = instr[20:16];
            end
            op_lw: begin
                dec.op_class = issue_pkg::lw;
                dec.rs_valid = 1'b1;
                writes       = 1'b1;
                dst          = instr[20:16];
            end
            op_sw: begin
                // base and store data are both read
                dec.op_class = issue_pkg::sw;
                dec.rs_valid = 1'b1;
                dec.rt_valid = 1'b1;
            end
            op_beq: begin
                dec.op_class = issue_pkg::beq;
                dec.rs_valid = 1'b1;
                dec.rt_valid = 1'b1;
            end
            op_j: begin
                dec.op_class = issue_pkg::j;
            end
            op_jal: begin
                // link register is always $31
                dec.op_class = issue_pkg::jal;
                writes       = 1'b1;
                dst          = 5'd31;
            end
            default: begin
                dec.op_class = issue_pkg::other;
            end
        endcase

        // a write to $0 is dropped and needs no allocation
        dec.has_dst = writes && (dst != 5'd0);
        dec.dst_lr  = dec.has_dst ? dst : 5'd0;
    end

endmodule

//--- fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  issue_pkg::decoded_t dec,
    input  logic                take,
    input  logic                resolve_valid,
    input  logic                resolve_mispredict,
    output logic [31:0]         imem_addr,
    output logic [31:0]         pc,
    output logic [31:0]         next_pc_pred
);

    logic [31:0] seq_pc;
    logic [31:0] br_target;
    logic [31:0] jump_addr;
    logic        pred_taken;
    logic [31:0] alt_pc;
    logic        rollback;

    assign imem_addr = pc;
    assign rollback  = resolve_valid && resolve_mispredict;

    assign seq_pc    = pc + 32'd4;
    assign br_target = seq_pc + {dec.imm[29:0], 2'b00};
    assign jump_addr = {pc[31:28], dec.jump_target, 2'b00};

    // backward branches are predicted taken
    assign pred_taken = dec.imm[31];

    always_comb begin
        case (dec.op_class)
            issue_pkg::beq: begin
                next_pc_pred = pred_taken ? br_target : seq_pc;
            end
            issue_pkg::j,
            issue_pkg::jal: begin
                next_pc_pred = jump_addr;
            end
            default: begin
                next_pc_pred = seq_pc;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= issue_pkg::reset_pc;
        end else if (rollback) begin
            pc <= alt_pc;
        end else if (take) begin
            pc <= next_pc_pred;
        end
    end

    // the path not predicted, used only on a misprediction
    always_ff @(posedge clk) begin
        if (take && dec.op_class == issue_pkg::beq) begin
            alt_pc <= pred_taken ? seq_pc : br_target;
        end
    end

endmodule

//--- rename_unit.sv
`timescale 1ns/1ps

module rename_unit #(
    parameter int num_phy_regs = 64
) (
    input  logic                clk,
    input  logic                rst_n,
    input  issue_pkg::decoded_t dec,
    input  logic                resolve_valid,
    input  logic                resolve_mispredict,
    rename_if.rename            ren
);

    localparam int pr_w = $clog2(num_phy_regs);

    // entry 0 stays at PR0 and is never written
    logic [pr_w-1:0]         map_q  [issue_pkg::num_logical];
    logic [pr_w-1:0]         ckpt_q [issue_pkg::num_logical];
    logic                    ckpt_valid;

    logic [num_phy_regs-1:0] used;
    logic [pr_w-1:0]         free_pr;
    logic                    free_found;
    logic                    is_beq;
    logic                    rollback;

    assign is_beq   = (dec.op_class == issue_pkg::beq);
    assign rollback = resolve_valid && resolve_mispredict;

    // registers held by the live table or the saved one
    always_comb begin
        used = '0;
        for (int lr = 1; lr < issue_pkg::num_logical; lr++) begin
            used[map_q[lr]] = 1'b1;
            if (ckpt_valid) begin
                used[ckpt_q[lr]] = 1'b1;
            end
        end
    end

    // scan downward so the last hit is the lowest free register
    always_comb begin
        free_pr    = '0;
        free_found = 1'b0;
        for (int pr = num_phy_regs - 1; pr >= issue_pkg::num_logical; pr--) begin
            if (!used[pr]) begin
                free_pr    = pr_w'(pr);
                free_found = 1'b1;
            end
        end
    end

    assign ren.phy_rs  = dec.rs_valid ? map_q[dec.rs] : '0;
    assign ren.phy_rt  = dec.rt_valid ? map_q[dec.rt] : '0;
    assign ren.phy_dst = dec.has_dst ? free_pr : '0;

    // only one branch may be in flight
    assign ren.ready = !(dec.has_dst && !free_found) && !(is_beq && ckpt_valid);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < issue_pkg::num_logical; i++) begin
                map_q[i] <= pr_w'(i);
            end
            ckpt_valid <= 1'b0;
        end else if (rollback) begin
            map_q      <= ckpt_q;
            ckpt_valid <= 1'b0;
        end else begin
            if (resolve_valid) begin
                ckpt_valid <= 1'b0;
            end
            if (ren.take) begin
                if (dec.has_dst) begin
                    map_q[dec.dst_lr] <= free_pr;
                end
                if (is_beq) begin
                    ckpt_valid <= 1'b1;
                end
            end
        end
    end

    // snapshot of the table as it stood before the branch
    always_ff @(posedge clk) begin
        if (ren.take && is_beq) begin
            ckpt_q <= map_q;
        end
    end

endmodule

//--- issue_stage.sv
`timescale 1ns/1ps

module issue_stage #(
    parameter int num_phy_regs = 64
) (
    input  logic                                clk,
    input  logic                                rst_n,
    rename_if.stage                             ren,
    input  issue_pkg::decoded_t                 dec,
    input  logic [31:0]                         pc,
    input  logic [31:0]                         next_pc_pred,
    input  logic                                resolve_valid,
    input  logic                                resolve_mispredict,
    input  logic                                issue_ack,
    output logic                                issue_req,
    output logic [31:0]                         issue_pc,
    output logic [7:0]                          issue_id,
    output issue_pkg::op_class_t                issue_class,
    output logic [$clog2(num_phy_regs)-1:0]     phy_rs,
    output logic [$clog2(num_phy_regs)-1:0]     phy_rt,
    output logic [$clog2(num_phy_regs)-1:0]     phy_dst,
    output logic [31:0]                         next_pc_pred_out
);

    logic [7:0] id_cnt;
    logic       idle;

    // four-phase handshake is idle only when both lines are low
    assign idle     = !issue_req && !issue_ack;
    assign ren.take = idle && ren.ready && !(resolve_valid && resolve_mispredict);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_req <= 1'b0;
            id_cnt    <= 8'd0;
        end else if (ren.take) begin
            issue_req <= 1'b1;
            id_cnt    <= id_cnt + 8'd1;
        end else if (issue_req && issue_ack) begin
            // consumer has the packet so req can fall
            issue_req <= 1'b0;
        end
    end

    // packet fields only change on a take, so they hold while req is high
    always_ff @(posedge clk) begin
        if (ren.take) begin
            issue_pc         <= pc;
            issue_id         <= id_cnt;
            issue_class      <= dec.op_class;
            phy_rs           <= ren.phy_rs;
            phy_rt           <= ren.phy_rt;
            phy_dst          <= ren.phy_dst;
            next_pc_pred_out <= next_pc_pred;
        end
    end

endmodule

//--- issue_top.sv
`timescale 1ns/1ps

module issue_top #(
    parameter int num_phy_regs = 64
) (
    input  logic                            clk,
    input  logic                            rst_n,
    output logic [31:0]                     imem_addr,
    input  logic [31:0]                     imem_data,
    input  logic                            resolve_valid,
    input  logic                            resolve_mispredict,
    output logic                            issue_req,
    input  logic                            issue_ack,
    output logic [31:0]                     issue_pc,
    output logic [7:0]                      issue_id,
    output issue_pkg::op_class_t            issue_class,
    output logic [$clog2(num_phy_regs)-1:0] phy_rs,
    output logic [$clog2(num_phy_regs)-1:0] phy_rt,
    output logic [$clog2(num_phy_regs)-1:0] phy_dst,
    output logic [31:0]                     next_pc_pred
);

    issue_pkg::decoded_t dec;
    logic [31:0]         fetch_pc;
    logic [31:0]         pred_pc;

    rename_if #(.num_phy_regs(num_phy_regs)) ren_bus ();

    opcode_decoder u_decoder (
        .instr (imem_data),
        .dec   (dec)
    );

    fetch_sequencer u_sequencer (
        .clk                (clk),
        .rst_n              (rst_n),
        .dec                (dec),
        .take               (ren_bus.take),
        .resolve_valid      (resolve_valid),
        .resolve_mispredict (resolve_mispredict),
        .imem_addr          (imem_addr),
        .pc                 (fetch_pc),
        .next_pc_pred       (pred_pc)
    );

    rename_unit #(.num_phy_regs(num_phy_regs)) u_rename (
        .clk                (clk),
        .rst_n              (rst_n),
        .dec                (dec),
        .resolve_valid      (resolve_valid),
        .resolve_mispredict (resolve_mispredict),
        .ren                (ren_bus.rename)
    );

    issue_stage #(.num_phy_regs(num_phy_regs)) u_stage (
        .clk                (clk),
        .rst_n              (rst_n),
        .ren                (ren_bus.stage),
        .dec                (dec),
        .pc                 (fetch_pc),
        .next_pc_pred       (pred_pc),
        .resolve_valid      (resolve_valid),
        .resolve_mispredict (resolve_mispredict),
        .issue_ack          (issue_ack),
        .issue_req          (issue_req),
        .issue_pc           (issue_pc),
        .issue_id           (issue_id),
        .issue_class        (issue_class),
        .phy_rs             (phy_rs),
        .phy_rt             (phy_rt),
        .phy_dst            (phy_dst),
        .next_pc_pred_out   (next_pc_pred)
    );

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int period       = 10,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // falling edge of rst_n clears the DUT before the first clock edge
    initial begin
        rst_n = 1'b1;
        #1 rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

//--- issue_sva.sv
`timescale 1ns/1ps

module issue_sva #(
    parameter int num_phy_regs = 64
) (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            issue_req,
    input logic                            issue_ack,
    input logic [31:0]                     issue_pc,
    input logic [7:0]                      issue_id,
    input issue_pkg::op_class_t            issue_class,
    input logic [$clog2(num_phy_regs)-1:0] phy_rs,
    input logic [$clog2(num_phy_regs)-1:0] phy_rt,
    input logic [$clog2(num_phy_regs)-1:0] phy_dst,
    input logic [31:0]                     next_pc_pred
);

    localparam int pr_w = $clog2(num_phy_regs);

    logic [76+3*pr_w-1:0] packet;

    assign packet = {issue_pc, issue_id, issue_class, phy_rs, phy_rt, phy_dst, next_pc_pred};

    // req may only fall after the consumer has acknowledged
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        issue_req && !issue_ack |=> issue_req)
        else $error("issue_req dropped before issue_ack was seen");

    packet_stable: assert property (@(posedge clk) disable iff (!rst_n)
        issue_req && $past(issue_req) |-> $stable(packet))
        else $error("issue packet changed while issue_req was high");

    req_low_in_reset: assert property (@(posedge clk) !rst_n |-> !issue_req)
        else $error("issue_req high during reset");

endmodule

bind issue_stage issue_sva #(.num_phy_regs(num_phy_regs)) u_sva (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue_req    (issue_req),
    .issue_ack    (issue_ack),
    .issue_pc     (issue_pc),
    .issue_id     (issue_id),
    .issue_class  (issue_class),
    .phy_rs       (phy_rs),
    .phy_rt       (phy_rt),
    .phy_dst      (phy_dst),
    .next_pc_pred (next_pc_pred_out)
);

//--- issue_tb.sv
`timescale 1ns/1ps

module issue_tb;

    localparam int num_phy_regs    = 64;
    localparam int n_steps         = 19;
    localparam int watchdog_cycles = n_steps * 16 + 10;

    logic                 clk;
    logic                 rst_n;
    logic [31:0]          imem_addr;
    logic [31:0]          imem_data;
    logic                 resolve_valid;
    logic                 resolve_mispredict;
    logic                 issue_req;
    logic                 issue_ack;
    logic [31:0]          issue_pc;
    logic [7:0]           issue_id;
    issue_pkg::op_class_t issue_class;
    logic [5:0]           phy_rs;
    logic [5:0]           phy_rt;
    logic [5:0]           phy_dst;
    logic [31:0]          next_pc_pred;

    logic [31:0] imem [64];
    // expected issue pc, resolve kind (0 none, 1 correct, 2 mispredict), stall cycles
    logic [39:0] steps [n_steps];

    // reference model of the rename table and checkpoint
    logic [5:0]  ref_map [32];
    logic [5:0]  ref_ckpt [32];
    logic        ref_ckpt_valid;
    logic [7:0]  ref_id;
    logic [31:0] lfsr;
    int          errors;

    tb_clock #(.period(10), .reset_cycles(3)) u_clock (.clk(clk), .rst_n(rst_n));

    issue_top #(.num_phy_regs(num_phy_regs)) uut (
        .clk                (clk),
        .rst_n              (rst_n),
        .imem_addr          (imem_addr),
        .imem_data          (imem_data),
        .resolve_valid      (resolve_valid),
        .resolve_mispredict (resolve_mispredict),
        .issue_req          (issue_req),
        .issue_ack          (issue_ack),
        .issue_pc           (issue_pc),
        .issue_id           (issue_id),
        .issue_class        (issue_class),
        .phy_rs             (phy_rs),
        .phy_rt             (phy_rt),
        .phy_dst            (phy_dst),
        .next_pc_pred       (next_pc_pred)
    );

    // instruction memory answers in the same cycle
    assign imem_data = imem[6'((imem_addr - issue_pkg::reset_pc) >> 2)];

    function automatic logic [31:0] r_word(input int rs, input int rt, input int rd,
                                           input logic [5:0] funct);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, funct};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input int rs, input int rt,
                                           input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] j_word(input logic [5:0] op, input logic [31:0] addr);
        return {op, addr[27:2]};
    endfunction

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int width, output int value);
        value = 0;
        for (int b = 0; b < width; b++) begin
            lfsr  = lfsr_next(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            $display("Checks failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // lowest register from 32 up that neither the table nor a live checkpoint holds
    function automatic logic [5:0] lowest_free();
        logic       busy;
        logic       found;
        logic [5:0] result;
        found  = 1'b0;
        result = 6'd0;
        for (int p = issue_pkg::num_logical; p < num_phy_regs; p++) begin
            busy = 1'b0;
            for (int r = 1; r < issue_pkg::num_logical; r++) begin
                if (ref_map[r] == 6'(p) || (ref_ckpt_valid && ref_ckpt[r] == 6'(p))) begin
                    busy = 1'b1;
                end
            end
            if (!busy && !found) begin
                result = 6'(p);
                found  = 1'b1;
            end
        end
        return result;
    endfunction

    task automatic check_packet(input logic [31:0] pc);
        logic [31:0]          w;
        logic [31:0]          seq;
        logic [31:0]          target;
        logic [31:0]          pred;
        issue_pkg::op_class_t cls;
        logic                 rs_used;
        logic                 rt_used;
        logic [4:0]           dst;
        logic [5:0]           new_pr;
        w      = imem[6'((pc - issue_pkg::reset_pc) >> 2)];
        seq    = pc + 32'd4;
        target = seq + {{14{w[15]}}, w[15:0], 2'b00};
        case (w[31:26])
            6'h00: cls = (w[5:0] == issue_pkg::funct_addu || w[5:0] == issue_pkg::funct_subu)
                         ? issue_pkg::alu_r : issue_pkg::other;
            6'h0d: cls = issue_pkg::ori;
            6'h0f: cls = issue_pkg::lui;
            6'h23: cls = issue_pkg::lw;
            6'h2b: cls = issue_pkg::sw;
            6'h04: cls = issue_pkg::beq;
            6'h02: cls = issue_pkg::j;
            6'h03: cls = issue_pkg::jal;
            default: cls = issue_pkg::other;
        endcase
        rs_used = cls inside {issue_pkg::alu_r, issue_pkg::ori, issue_pkg::lw, issue_pkg::sw,
                              issue_pkg::beq};
        rt_used = cls inside {issue_pkg::alu_r, issue_pkg::sw, issue_pkg::beq};
        case (cls)
            issue_pkg::alu_r: dst = w[15:11];
            issue_pkg::ori, issue_pkg::lui, issue_pkg::lw: dst = w[20:16];
            issue_pkg::jal: dst = 5'd31;
            default: dst = 5'd0;
        endcase
        // backward branches predicted taken
        case (cls)
            issue_pkg::beq: pred = w[15] ? target : seq;
            issue_pkg::j, issue_pkg::jal: pred = {pc[31:28], w[25:0], 2'b00};
            default: pred = seq;
        endcase
        new_pr = lowest_free();
        compare_value("issue_pc", issue_pc, pc);
        compare_value("issue_id", 32'(issue_id), 32'(ref_id));
        compare_value("issue_class", 32'(issue_class), 32'(cls));
        compare_value("phy_rs", 32'(phy_rs), rs_used ? 32'(ref_map[w[25:21]]) : 32'd0);
        compare_value("phy_rt", 32'(phy_rt), rt_used ? 32'(ref_map[w[20:16]]) : 32'd0);
        compare_value("phy_dst", 32'(phy_dst), (dst != 5'd0) ? 32'(new_pr) : 32'd0);
        compare_value("next_pc_pred", next_pc_pred, pred);
        // fetch has already moved on to the predicted path
        compare_value("imem_addr", imem_addr, pred);
        if (cls == issue_pkg::beq) begin
            ref_ckpt       = ref_map;
            ref_ckpt_valid = 1'b1;
        end
        if (dst != 5'd0) begin
            ref_map[dst] = new_pr;
        end
        ref_id = ref_id + 8'd1;
    endtask

    task automatic send_resolve(input logic mispredict);
        resolve_valid      = 1'b1;
        resolve_mispredict = mispredict;
        wait_cycle();
        resolve_valid      = 1'b0;
        resolve_mispredict = 1'b0;
        ref_ckpt_valid     = 1'b0;
        if (mispredict) begin
            ref_map = ref_ckpt;
        end
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired before all packets were issued");
        $display("Checks failed");
        $fatal(1, "timeout");
    end

    initial begin
        int          ack_wait;
        logic [31:0] exp_pc;
        logic [3:0]  kind;
        logic [3:0]  stall;
        errors             = 0;
        lfsr               = 32'ha996;
        issue_ack          = 1'b0;
        resolve_valid      = 1'b0;
        resolve_mispredict = 1'b0;
        ref_ckpt_valid     = 1'b0;
        ref_id             = 8'd0;
        for (int r = 0; r < 32; r++) begin
            ref_map[r]  = 6'(r);
            ref_ckpt[r] = 6'(r);
        end
        for (int i = 0; i < 64; i++) begin
            imem[i] = ~(issue_pkg::reset_pc + 32'(i * 4));
        end
        imem[0]  = r_word(1, 2, 3, issue_pkg::funct_addu);
        imem[1]  = i_word(6'h0d, 3, 4, 'h0012);
        imem[2]  = i_word(6'h0f, 0, 5, 'h1234);
        imem[3]  = i_word(6'h23, 4, 6, 4);
        imem[4]  = i_word(6'h2b, 5, 6, 8);
        imem[5]  = r_word(6, 3, 0, issue_pkg::funct_addu);
        imem[6]  = r_word(3, 6, 3, issue_pkg::funct_subu);
        imem[7]  = i_word(6'h04, 3, 4, -2);
        imem[8]  = i_word(6'h0d, 3, 7, 1);
        imem[9]  = i_word(6'h04, 0, 0, 3);
        imem[10] = r_word(7, 3, 8, issue_pkg::funct_addu);
        imem[11] = i_word(6'h04, 8, 0, 1);
        imem[13] = j_word(6'h03, 32'h0000_3040);
        imem[16] = j_word(6'h02, 32'h0000_3048);
        imem[18] = r_word(31, 8, 9, issue_pkg::funct_addu);
        imem[19] = i_word(6'h04, 9, 9, -4);
        steps = '{
            {32'h3000, 4'd0, 4'd0}, {32'h3004, 4'd0, 4'd0}, {32'h3008, 4'd0, 4'd0},
            {32'h300c, 4'd0, 4'd0}, {32'h3010, 4'd0, 4'd0}, {32'h3014, 4'd0, 4'd0},
            {32'h3018, 4'd0, 4'd0}, {32'h301c, 4'd0, 4'd0}, {32'h3018, 4'd2, 4'd0},
            {32'h3020, 4'd0, 4'd0}, {32'h3024, 4'd0, 4'd0}, {32'h3028, 4'd1, 4'd3},
            {32'h302c, 4'd2, 4'd0}, {32'h3034, 4'd0, 4'd0}, {32'h3040, 4'd0, 4'd0},
            {32'h3048, 4'd0, 4'd0}, {32'h304c, 4'd1, 4'd0}, {32'h3040, 4'd0, 4'd0},
            {32'h3048, 4'd0, 4'd0}
        };
        @(posedge rst_n);
        for (int s = 0; s < n_steps; s++) begin
            {exp_pc, kind, stall} = steps[s];
            wait_cycle();
            while (!issue_req) begin
                wait_cycle();
            end
            check_packet(exp_pc);
            draw_bits(2, ack_wait);
            repeat (ack_wait) wait_cycle();
            issue_ack = 1'b1;
            wait_cycle();
            while (issue_req) begin
                wait_cycle();
            end
            // resolve while ack still blocks the next take
            if (kind != 4'd0 && stall == 4'd0) begin
                send_resolve(kind == 4'd2);
            end
            issue_ack = 1'b0;
            // next beq must wait for this resolve
            if (kind != 4'd0 && stall != 4'd0) begin
                repeat (stall) begin
                    wait_cycle();
                    compare_value("issue_req", 32'(issue_req), 32'd0);
                end
                send_resolve(kind == 4'd2);
            end
        end
        if (errors == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "errors found");
        end
    end

endmodule

//--- sim.f
issue_pkg.sv
rename_if.sv
opcode_decoder.sv
fetch_sequencer.sv
rename_unit.sv
issue_stage.sv
issue_top.sv
tb_clock.sv
issue_sva.sv
issue_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module issue_tb -f sim.f -o issue_sim
./obj_dir/issue_sim
